/* common/csrPkg.sv */
//////////////////////////////////////////////////
// CSR package
// Widths, CSR addresses, fixed values and access op type
//////////////////////////////////////////////////

package csrPkg;

  //////////////////////////////////////////////////
  // Sizes

  localparam int Xlen       = 32;
  localparam int PmpEntries = 4;
  localparam int PmpIdxBits = $clog2(PmpEntries);
  // pmpaddr holds PA bits 33:2
  localparam int PaBits     = 34;

  //////////////////////////////////////////////////
  // Machine CSR addresses

  // Read-only ID registers
  localparam logic [11:0] AdrMvendorid     = 12'hF11;
  localparam logic [11:0] AdrMarchid       = 12'hF12;
  localparam logic [11:0] AdrMimpid        = 12'hF13;
  localparam logic [11:0] AdrMhartid       = 12'hF14;
  localparam logic [11:0] AdrMconfigptr    = 12'hF15;

  // Trap setup
  localparam logic [11:0] AdrMstatus       = 12'h300;
  localparam logic [11:0] AdrMisa          = 12'h301;
  localparam logic [11:0] AdrMedeleg       = 12'h302;
  localparam logic [11:0] AdrMideleg       = 12'h303;
  localparam logic [11:0] AdrMie           = 12'h304;
  localparam logic [11:0] AdrMtvec         = 12'h305;
  localparam logic [11:0] AdrMstatush      = 12'h310;
  localparam logic [11:0] AdrMcountinhibit = 12'h320;

  // Trap handling
  localparam logic [11:0] AdrMscratch      = 12'h340;
  localparam logic [11:0] AdrMepc          = 12'h341;
  localparam logic [11:0] AdrMcause        = 12'h342;
  localparam logic [11:0] AdrMtval         = 12'h343;
  localparam logic [11:0] AdrMip           = 12'h344;

  // PMP, entries sit at consecutive addresses
  localparam logic [11:0] AdrPmpcfg0       = 12'h3A0;
  localparam logic [11:0] AdrPmpaddr0      = 12'h3B0;

  //////////////////////////////////////////////////
  // Fixed values

  localparam logic [Xlen-1:0] MvendoridVal = 32'h0;
  localparam logic [Xlen-1:0] MarchidVal   = 32'h24;
  localparam logic [Xlen-1:0] MimpidVal    = 32'h100;
  // RV32 with I and M
  localparam logic [Xlen-1:0] MisaVal      = 32'h4000_1100;

  // MSI, MTI and MEI
  localparam logic [11:0] MipMask = 12'h888;

  // mstatus field positions
  localparam int MstatusMie  = 3;
  localparam int MstatusMpie = 7;
  localparam int MstatusMpp  = 11;

  typedef enum logic [1:0] {
    CsrRead,
    CsrWrite,
    CsrSet,
    CsrClear
  } csrOpT;

endpackage

/* csr/csrAccess.sv */
//////////////////////////////////////////////////
// CSR access sequencer
// Four-phase req/ack slave, forms write value, latches read
//////////////////////////////////////////////////
`timescale 1ns/10ps

module csrAccess import csrPkg::*; (
  input  logic            clk,
  input  logic            arstN,
  input  logic            req,
  input  csrOpT           op,
  input  logic [11:0]     adr,
  input  logic [Xlen-1:0] wdata,
  input  logic [Xlen-1:0] readVal,
  input  logic            illegalAccess,
  output logic            ack,
  output logic [Xlen-1:0] rdata,
  output logic            illegal,
  output logic            ungatedWrite,
  output logic            csrWrite,
  output logic [Xlen-1:0] csrWdata,
  output logic [11:0]     csrAdr
);

  logic accept;

  // A new request is taken only once ack has dropped
  assign accept = req & ~ack;

  assign csrAdr = adr;

  // New value from the old one for set and clear
  always_comb begin
    case (op)
      CsrWrite: csrWdata = wdata;
      CsrSet:   csrWdata = readVal | wdata;
      CsrClear: csrWdata = readVal & ~wdata;
      default:  csrWdata = readVal;
    endcase
  end

  // Single-cycle pulse, ack is high right after the accept edge
  assign ungatedWrite = accept & (op != CsrRead);
  assign csrWrite     = ungatedWrite & ~illegalAccess;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ack     <= 1'b0;
      rdata   <= '0;
      illegal <= 1'b0;
    end else begin
      if (accept) begin
        ack     <= 1'b1;
        // Old register contents go back to the master
        rdata   <= readVal;
        illegal <= illegalAccess;
      end else if (!req) begin
        ack <= 1'b0;
      end
    end
  end

endmodule

/* csr/csrm.sv */
//////////////////////////////////////////////////
// Machine CSRs
// Trap registers, PMP entries, read decode and illegal check
//////////////////////////////////////////////////
`timescale 1ns/10ps

module csrm import csrPkg::*; (
  input  logic            clk,
  input  logic            arstN,
  input  logic            ungatedWrite,
  input  logic            csrWrite,
  input  logic [11:0]     csrAdr,
  input  logic [Xlen-1:0] csrWdata,
  input  logic            trap,
  input  logic [Xlen-1:0] nextEpc,
  input  logic [4:0]      nextCause,
  input  logic [Xlen-1:0] nextTval,
  input  logic [Xlen-1:0] mstatus,
  input  logic [11:0]     mieReg,
  input  logic [11:0]     mipReg,
  output logic [Xlen-1:0] readVal,
  output logic            illegalAccess,
  output logic            writeMstatus,
  output logic [Xlen-1:0] mtvec,
  output logic [Xlen-1:0] mepc
);

  logic [Xlen-1:0]   mscratch;
  logic [Xlen-1:0]   mcause;
  logic [Xlen-1:0]   mtval;
  logic [Xlen-1:0]   mcountinhibit;
  logic [7:0]        pmpCfg [PmpEntries];
  logic [PaBits-3:0] pmpAddr [PmpEntries];
  logic [Xlen-1:0]   pmpCfgWord;
  logic [11:0]       pmpOffset;
  logic              idReg;

  assign writeMstatus = csrWrite & (csrAdr == AdrMstatus);

  //////////////////////////////////////////////////
  // Trap and scratch registers

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mtvec         <= '0;
      mscratch      <= '0;
      mepc          <= '0;
      mcause        <= '0;
      mtval         <= '0;
      mcountinhibit <= '0;
    end else begin
      // Bit 1 is reserved in the mode field
      if (csrWrite && csrAdr == AdrMtvec)
        mtvec <= {csrWdata[Xlen-1:2], 1'b0, csrWdata[0]};
      if (csrWrite && csrAdr == AdrMscratch)
        mscratch <= csrWdata;
      if (csrWrite && csrAdr == AdrMcountinhibit)
        mcountinhibit <= csrWdata;
      // Trap beats a CSR write to the same register
      if (trap) begin
        mepc   <= nextEpc;
        mcause <= {nextCause[4], {(Xlen-5){1'b0}}, nextCause[3:0]};
        mtval  <= nextTval;
      end else begin
        if (csrWrite && csrAdr == AdrMepc)   mepc   <= csrWdata;
        if (csrWrite && csrAdr == AdrMcause) mcause <= csrWdata;
        if (csrWrite && csrAdr == AdrMtval)  mtval  <= csrWdata;
      end
    end
  end

  //////////////////////////////////////////////////
  // PMP entries

  for (genvar i = 0; i < PmpEntries; i++) begin : gPmp
    localparam logic [11:0] PmpAddrAdr = AdrPmpaddr0 + 12'(i);
    logic cfgLocked;
    logic addrLocked;

    assign cfgLocked = pmpCfg[i][7];
    // A locked TOR entry above also freezes this address
    if (i == PmpEntries - 1) begin : gLast
      assign addrLocked = cfgLocked;
    end else begin : gTor
      assign addrLocked = cfgLocked | (pmpCfg[i+1][7] & (pmpCfg[i+1][4:3] == 2'b01));
    end

    always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
        pmpCfg[i]  <= '0;
        pmpAddr[i] <= '0;
      end else begin
        if (csrWrite && csrAdr == AdrPmpcfg0 && !cfgLocked)
          pmpCfg[i] <= csrWdata[i*8 +: 8];
        if (csrWrite && csrAdr == PmpAddrAdr && !addrLocked)
          pmpAddr[i] <= csrWdata[PaBits-3:0];
      end
    end
  end

  always_comb begin
    for (int k = 0; k < PmpEntries; k++)
      pmpCfgWord[k*8 +: 8] = pmpCfg[k];
  end

  //////////////////////////////////////////////////
  // Read decode

  // Wraps to a large value below the pmpaddr base
  assign pmpOffset = csrAdr - AdrPmpaddr0;
  assign idReg = csrAdr inside {AdrMvendorid, AdrMarchid, AdrMimpid, AdrMhartid,
                                AdrMconfigptr};

  always_comb begin
    readVal       = '0;
    illegalAccess = 1'b0;
    if (pmpOffset < 12'(PmpEntries)) begin
      readVal = Xlen'(pmpAddr[pmpOffset[PmpIdxBits-1:0]]);
    end else begin
      case (csrAdr)
        AdrMvendorid:     readVal = MvendoridVal;
        AdrMarchid:       readVal = MarchidVal;
        AdrMimpid:        readVal = MimpidVal;
        AdrMisa:          readVal = MisaVal;
        AdrMhartid, AdrMconfigptr, AdrMstatush: readVal = '0;
        AdrMstatus:       readVal = mstatus;
        AdrMie:           readVal = Xlen'(mieReg);
        AdrMip:           readVal = Xlen'(mipReg);
        AdrMtvec:         readVal = mtvec;
        AdrMcountinhibit: readVal = mcountinhibit;
        AdrMscratch:      readVal = mscratch;
        AdrMepc:          readVal = mepc;
        AdrMcause:        readVal = mcause;
        AdrMtval:         readVal = mtval;
        AdrPmpcfg0:       readVal = pmpCfgWord;
        // No S-mode so delegation does not exist
        AdrMedeleg, AdrMideleg: illegalAccess = 1'b1;
        default:          illegalAccess = 1'b1;
      endcase
    end
    // ID registers are read-only
    illegalAccess = illegalAccess | (ungatedWrite & idReg);
  end

endmodule

/* csr/csrsr.sv */
//////////////////////////////////////////////////
// mstatus register
// MIE and MPIE with trap entry and mret updates
//////////////////////////////////////////////////
`timescale 1ns/10ps

module csrsr import csrPkg::*; (
  input  logic            clk,
  input  logic            arstN,
  input  logic            writeMstatus,
  input  logic [Xlen-1:0] csrWdata,
  input  logic            trap,
  input  logic            mret,
  output logic [Xlen-1:0] mstatus,
  output logic            mieBit
);

  logic mie;
  logic mpie;

  // Trap stacks MIE, mret pops it
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mie  <= 1'b0;
      mpie <= 1'b0;
    end else if (trap) begin
      mpie <= mie;
      mie  <= 1'b0;
    end else if (mret) begin
      mie  <= mpie;
      mpie <= 1'b1;
    end else if (writeMstatus) begin
      mie  <= csrWdata[MstatusMie];
      mpie <= csrWdata[MstatusMpie];
    end
  end

  // Only M-mode exists so MPP is fixed at 11
  always_comb begin
    mstatus                 = '0;
    mstatus[MstatusMie]     = mie;
    mstatus[MstatusMpie]    = mpie;
    mstatus[MstatusMpp +: 2] = 2'b11;
  end

  assign mieBit = mie;

endmodule

/* csr/csri.sv */
//////////////////////////////////////////////////
// Interrupt CSRs
// mie, registered mip and the pending interrupt flag
//////////////////////////////////////////////////
`timescale 1ns/10ps

module csri import csrPkg::*; (
  input  logic            clk,
  input  logic            arstN,
  input  logic            csrWrite,
  input  logic [11:0]     csrAdr,
  input  logic [Xlen-1:0] csrWdata,
  input  logic            mtip,
  input  logic            msip,
  input  logic            meip,
  input  logic            mieBit,
  output logic [11:0]     mieReg,
  output logic [11:0]     mipReg,
  output logic            irqPending
);

  logic [11:0] irqLines;

  // External at 11, timer at 7, software at 3
  assign irqLines = {meip, 3'b000, mtip, 3'b000, msip, 3'b000};

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mieReg <= '0;
      mipReg <= '0;
    end else begin
      if (csrWrite && csrAdr == AdrMie)
        mieReg <= csrWdata[11:0] & MipMask;
      mipReg <= irqLines & MipMask;
    end
  end

  assign irqPending = (|(mipReg & mieReg)) & mieBit;

endmodule

/* csr/csr.sv */
//////////////////////////////////////////////////
// CSR block top
// Access port, trap port and interrupt lines for an M-mode core
//////////////////////////////////////////////////
`timescale 1ns/10ps

module csr import csrPkg::*; (
  input  logic            clk,
  input  logic            arstN,
  // Access port
  input  logic            req,
  input  csrOpT           op,
  input  logic [11:0]     adr,
  input  logic [Xlen-1:0] wdata,
  output logic            ack,
  output logic [Xlen-1:0] rdata,
  output logic            illegal,
  // Trap port
  input  logic            trap,
  input  logic [Xlen-1:0] nextEpc,
  input  logic [4:0]      nextCause,
  input  logic [Xlen-1:0] nextTval,
  input  logic            mret,
  // Interrupt lines
  input  logic            mtip,
  input  logic            msip,
  input  logic            meip,
  output logic [Xlen-1:0] mtvec,
  output logic [Xlen-1:0] mepc,
  output logic            irqPending
);

  logic            ungatedWrite;
  logic            csrWrite;
  logic [Xlen-1:0] csrWdata;
  logic [11:0]     csrAdr;
  logic [Xlen-1:0] readVal;
  logic            illegalAccess;
  logic            writeMstatus;
  logic [Xlen-1:0] mstatus;
  logic            mieBit;
  logic [11:0]     mieReg;
  logic [11:0]     mipReg;

  csrAccess uAccess (
    .clk(clk), .arstN(arstN), .req(req), .op(op), .adr(adr), .wdata(wdata),
    .readVal(readVal), .illegalAccess(illegalAccess), .ack(ack), .rdata(rdata),
    .illegal(illegal), .ungatedWrite(ungatedWrite), .csrWrite(csrWrite),
    .csrWdata(csrWdata), .csrAdr(csrAdr)
  );

  csrm uCsrm (
    .clk(clk), .arstN(arstN), .ungatedWrite(ungatedWrite), .csrWrite(csrWrite),
    .csrAdr(csrAdr), .csrWdata(csrWdata), .trap(trap), .nextEpc(nextEpc),
    .nextCause(nextCause), .nextTval(nextTval), .mstatus(mstatus), .mieReg(mieReg),
    .mipReg(mipReg), .readVal(readVal), .illegalAccess(illegalAccess),
    .writeMstatus(writeMstatus), .mtvec(mtvec), .mepc(mepc)
  );

  csrsr uCsrsr (
    .clk(clk), .arstN(arstN), .writeMstatus(writeMstatus), .csrWdata(csrWdata),
    .trap(trap), .mret(mret), .mstatus(mstatus), .mieBit(mieBit)
  );

  // mie decode lives with the interrupt logic
  csri uCsri (
    .clk(clk), .arstN(arstN), .csrWrite(csrWrite), .csrAdr(csrAdr),
    .csrWdata(csrWdata), .mtip(mtip), .msip(msip), .meip(meip), .mieBit(mieBit),
    .mieReg(mieReg), .mipReg(mipReg), .irqPending(irqPending)
  );

endmodule

/* verif/csr_props.sv */
//////////////////////////////////////////////////
// Access sequencer properties
//////////////////////////////////////////////////
`timescale 1ns/10ps

module csrProps (
  input logic clk,
  input logic arstN,
  input logic req,
  input logic ack,
  input logic illegal,
  input logic ungatedWrite,
  input logic csrWrite,
  input logic illegalAccess
);

  ackRiseNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
    $rose(ack) |-> $past(req))
    else $error("ack rose without req");

  ackFallNeedsNoReq: assert property (@(posedge clk) disable iff (!arstN)
    $fell(ack) |-> !$past(req))
    else $error("ack fell while req was high");

  // A blocked write is acked and flagged to the master
  illegalWriteFlagged: assert property (@(posedge clk) disable iff (!arstN)
    ungatedWrite && illegalAccess |=> ack && illegal)
    else $error("illegal write not reported to the master");

  // One write pulse per accepted access
  writeSingleCycle: assert property (@(posedge clk) disable iff (!arstN)
    ungatedWrite |=> !ungatedWrite)
    else $error("ungatedWrite longer than one cycle");

endmodule

bind csrAccess csrProps uProps (
  .clk(clk), .arstN(arstN), .req(req), .ack(ack), .illegal(illegal),
  .ungatedWrite(ungatedWrite), .csrWrite(csrWrite), .illegalAccess(illegalAccess)
);

/* verif/csrTb.sv */
//////////////////////////////////////////////////
// CSR testbench
// Directed access, trap, PMP and interrupt tests
//////////////////////////////////////////////////
`timescale 1ns/10ps

module csrTb import csrPkg::*; ();

  localparam int ClkPeriod     = 40;
  // 200 accesses of at most 6 cycles each
  localparam int TimeoutCycles = 200 * 6;

  // MPP at bits 12:11 always reads 11
  localparam logic [Xlen-1:0] MppBits  = 32'h0000_1800;
  localparam logic [Xlen-1:0] MieMask  = 32'h0000_0008;
  localparam logic [Xlen-1:0] MpieMask = 32'h0000_0080;

  logic            clk;
  logic            arstN;
  logic            req;
  csrOpT           op;
  logic [11:0]     adr;
  logic [Xlen-1:0] wdata;
  logic            ack;
  logic [Xlen-1:0] rdata;
  logic            illegal;
  logic            trap;
  logic [Xlen-1:0] nextEpc;
  logic [4:0]      nextCause;
  logic [Xlen-1:0] nextTval;
  logic            mret;
  logic            mtip;
  logic            msip;
  logic            meip;
  logic [Xlen-1:0] mtvec;
  logic [Xlen-1:0] mepc;
  logic            irqPending;
  int              seed;
  int              cycleCount = 0;
  logic [Xlen-1:0] scratchModel;
  logic [Xlen-1:0] tvecModel;

  csr uut (
    .clk(clk), .arstN(arstN), .req(req), .op(op), .adr(adr), .wdata(wdata),
    .ack(ack), .rdata(rdata), .illegal(illegal), .trap(trap), .nextEpc(nextEpc),
    .nextCause(nextCause), .nextTval(nextTval), .mret(mret), .mtip(mtip),
    .msip(msip), .meip(meip), .mtvec(mtvec), .mepc(mepc), .irqPending(irqPending)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount == TimeoutCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
      $display("*** FAILED ***");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  //////////////////////////////////////////////////
  // Compare tasks

  task automatic checkWord(input string name, input logic [Xlen-1:0] got,
                           input logic [Xlen-1:0] exp);
    if (got !== exp) begin
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "Word mismatch");
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "Bit mismatch");
    end
  endtask

  //////////////////////////////////////////////////
  // Access helpers

  // Write, set and clear rules of the access port
  function automatic logic [Xlen-1:0] opResult(input csrOpT o, input logic [Xlen-1:0] old,
                                               input logic [Xlen-1:0] d);
    case (o)
      CsrWrite: return d;
      CsrSet:   return old | d;
      CsrClear: return old & ~d;
      default:  return old;
    endcase
  endfunction

  // Four-phase handshake, returns the latched result
  task automatic csrAccessOp(input csrOpT o, input logic [11:0] a, input logic [Xlen-1:0] d,
                             output logic [Xlen-1:0] rd, output logic il);
    @(posedge clk);
    req   <= 1'b1;
    op    <= o;
    adr   <= a;
    wdata <= d;
    do @(negedge clk); while (!ack);
    rd = rdata;
    il = illegal;
    @(posedge clk);
    req <= 1'b0;
    do @(negedge clk); while (ack);
  endtask

  task automatic accessAndCheck(input csrOpT o, input logic [11:0] a,
                                input logic [Xlen-1:0] d, input logic [Xlen-1:0] expRd,
                                input logic expIl, input string name);
    logic [Xlen-1:0] rd;
    logic            il;
    csrAccessOp(o, a, d, rd, il);
    checkWord(name, rd, expRd);
    checkBit("illegal", il, expIl);
  endtask

  task automatic readCheck(input logic [11:0] a, input logic [Xlen-1:0] exp,
                           input string name);
    accessAndCheck(CsrRead, a, '0, exp, 1'b0, name);
  endtask

  task automatic illegalCheck(input csrOpT o, input logic [11:0] a);
    logic [Xlen-1:0] rd;
    logic            il;
    csrAccessOp(o, a, $random(seed), rd, il);
    checkBit("illegal", il, 1'b1);
  endtask

  //////////////////////////////////////////////////
  // Tests

  task automatic resetValues();
    readCheck(AdrMisa, MisaVal, "misa");
    readCheck(AdrMvendorid, MvendoridVal, "mvendorid");
    readCheck(AdrMarchid, MarchidVal, "marchid");
    readCheck(AdrMimpid, MimpidVal, "mimpid");
    readCheck(AdrMhartid, '0, "mhartid");
    readCheck(AdrMstatus, MppBits, "mstatus");
    illegalCheck(CsrWrite, AdrMvendorid);
    readCheck(AdrMvendorid, MvendoridVal, "mvendorid");
  endtask

  task automatic readWriteOps();
    csrOpT           ops [3] = '{CsrWrite, CsrSet, CsrClear};
    logic [Xlen-1:0] d;
    for (int i = 0; i < 6; i++) begin
      d = $random(seed);
      accessAndCheck(ops[i % 3], AdrMscratch, d, scratchModel, 1'b0, "mscratch");
      scratchModel = opResult(ops[i % 3], scratchModel, d);
      d = $random(seed);
      accessAndCheck(ops[i % 3], AdrMtvec, d, tvecModel, 1'b0, "mtvec");
      // Bit 1 of mtvec never sticks
      tvecModel = opResult(ops[i % 3], tvecModel, d) & ~32'h2;
    end
    readCheck(AdrMscratch, scratchModel, "mscratch");
    readCheck(AdrMtvec, tvecModel, "mtvec");
    checkWord("mtvec", mtvec, tvecModel);
  endtask

  task automatic illegalAddresses();
    logic [11:0] adrs [3] = '{12'h7C5, AdrMedeleg, AdrMideleg};
    for (int i = 0; i < 3; i++) begin
      illegalCheck(CsrRead, adrs[i]);
      illegalCheck(CsrWrite, adrs[i]);
    end
    readCheck(AdrMscratch, scratchModel, "mscratch");
    readCheck(AdrMtvec, tvecModel, "mtvec");
    readCheck(AdrMstatus, MppBits, "mstatus");
  endtask

  task automatic trapAndReturn();
    logic [Xlen-1:0] epc;
    logic [Xlen-1:0] tval;
    logic [4:0]      cause;
    logic [Xlen-1:0] expCause;
    epc      = $random(seed);
    tval     = $random(seed);
    cause    = 5'h1B;
    // Interrupt flag to bit 31, code in the low bits
    expCause = (cause[4] ? 32'h8000_0000 : 32'h0) | 32'(cause[3:0]);
    accessAndCheck(CsrWrite, AdrMstatus, MieMask, MppBits, 1'b0, "mstatus");
    checkWord("mepc", mepc, '0);
    @(posedge clk);
    trap      <= 1'b1;
    nextEpc   <= epc;
    nextCause <= cause;
    nextTval  <= tval;
    @(posedge clk);
    trap <= 1'b0;
    @(negedge clk);
    checkWord("mepc", mepc, epc);
    readCheck(AdrMepc, epc, "mepc");
    readCheck(AdrMcause, expCause, "mcause");
    readCheck(AdrMtval, tval, "mtval");
    readCheck(AdrMstatus, MppBits | MpieMask, "mstatus");
    @(posedge clk);
    mret <= 1'b1;
    @(posedge clk);
    mret <= 1'b0;
    readCheck(AdrMstatus, MppBits | MpieMask | MieMask, "mstatus");
  endtask

  task automatic pmpLocking();
    logic [Xlen-1:0] addrs [PmpEntries];
    logic [Xlen-1:0] cfg;
    logic [Xlen-1:0] lockedCfg;
    logic [Xlen-1:0] d;
    for (int i = 0; i < PmpEntries; i++) begin
      addrs[i] = $random(seed);
      accessAndCheck(CsrWrite, AdrPmpaddr0 + 12'(i), addrs[i], '0, 1'b0, "pmpaddr");
      readCheck(AdrPmpaddr0 + 12'(i), addrs[i], "pmpaddr");
    end
    cfg = $random(seed) & 32'h7F7F_7F7F;
    accessAndCheck(CsrWrite, AdrPmpcfg0, cfg, '0, 1'b0, "pmpcfg0");
    readCheck(AdrPmpcfg0, cfg, "pmpcfg0");
    // Entry 1 gets L set and A at TOR
    lockedCfg = {cfg[31:16], 8'h88, cfg[7:0]};
    accessAndCheck(CsrWrite, AdrPmpcfg0, lockedCfg, cfg, 1'b0, "pmpcfg0");
    d = $random(seed) & 32'h7F7F_7F7F;
    accessAndCheck(CsrWrite, AdrPmpcfg0, d, lockedCfg, 1'b0, "pmpcfg0");
    readCheck(AdrPmpcfg0, {d[31:16], 8'h88, d[7:0]}, "pmpcfg0");
    // pmpaddr0 and pmpaddr1 frozen, pmpaddr2 open
    for (int i = 0; i < 3; i++) begin
      d = $random(seed);
      accessAndCheck(CsrWrite, AdrPmpaddr0 + 12'(i), d, addrs[i], 1'b0, "pmpaddr");
      if (i == 2)
        addrs[i] = d;
      readCheck(AdrPmpaddr0 + 12'(i), addrs[i], "pmpaddr");
    end
  endtask

  task automatic interrupts();
    @(posedge clk);
    meip <= 1'b1;
    readCheck(AdrMip, 32'h800, "mip");
    checkBit("irqPending", irqPending, 1'b0);
    accessAndCheck(CsrWrite, AdrMie, 32'hFFFF_FFFF, '0, 1'b0, "mie");
    readCheck(AdrMie, 32'h888, "mie");
    checkBit("irqPending", irqPending, 1'b1);
    accessAndCheck(CsrClear, AdrMstatus, MieMask, MppBits | MpieMask | MieMask, 1'b0,
                   "mstatus");
    checkBit("irqPending", irqPending, 1'b0);
    accessAndCheck(CsrSet, AdrMstatus, MieMask, MppBits | MpieMask, 1'b0, "mstatus");
    checkBit("irqPending", irqPending, 1'b1);
    // Only the external enable is dropped
    accessAndCheck(CsrWrite, AdrMie, 32'h0000_0088, 32'h888, 1'b0, "mie");
    checkBit("irqPending", irqPending, 1'b0);
    @(posedge clk);
    meip <= 1'b0;
    readCheck(AdrMip, '0, "mip");
  endtask

  //////////////////////////////////////////////////
  // Main sequence

  initial begin
    seed         = 32'h5361;
    scratchModel = '0;
    tvecModel    = '0;
    arstN        <= 1'b0;
    req          <= 1'b0;
    op           <= CsrRead;
    adr          <= '0;
    wdata        <= '0;
    trap         <= 1'b0;
    nextEpc      <= '0;
    nextCause    <= '0;
    nextTval     <= '0;
    mret         <= 1'b0;
    mtip         <= 1'b0;
    msip         <= 1'b0;
    meip         <= 1'b0;
    repeat (3) @(posedge clk);
    arstN <= 1'b1;
    @(negedge clk);
    checkBit("ack", ack, 1'b0);
    checkBit("illegal", illegal, 1'b0);
    checkWord("rdata", rdata, '0);
    resetValues();
    readWriteOps();
    illegalAddresses();
    trapAndReturn();
    pmpLocking();
    interrupts();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* verilog.f */
common/csrPkg.sv
csr/csrAccess.sv
csr/csrm.sv
csr/csrsr.sv
csr/csri.sv
csr/csr.sv
verif/csr_props.sv
verif/csrTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the CSR testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f verilog.f --top-module csrTb -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/VcsrTb; then
  echo "Simulation reported a failure"
  exit 1
fi

echo "Simulation finished"
exit 0
